//--- rtl/cic_cfg.svh
// --------------------------------------------------------------------------
// cic decimator configuration
// widths, stage count and ratio limits shared by the whole design
// --------------------------------------------------------------------------
`ifndef CIC_CFG_SVH
`define CIC_CFG_SVH

// sample and datapath widths
`define CIC_IN_WIDTH    16
`define CIC_ACC_WIDTH   80
`define CIC_OUT_WIDTH   32

// number of integrators and of combs
`define CIC_STAGES      3

// ratio and shift controls
`define CIC_RATE_WIDTH  16
`define CIC_MIN_RATE    2
`define CIC_SHIFT_WIDTH 7

`endif

//--- rtl/cic_pkg.sv
// --------------------------------------------------------------------------
// cic decimator package
// sample, accumulator and output types plus the small state enums
// --------------------------------------------------------------------------
`default_nettype none

`include "cic_cfg.svh"

package cic_pkg;

  // signed input sample
  typedef logic signed [`CIC_IN_WIDTH-1:0] sample_t;

  // accumulator word, wraps in two's complement
  typedef logic signed [`CIC_ACC_WIDTH-1:0] acc_t;

  // scaled and saturated result
  typedef logic signed [`CIC_OUT_WIDTH-1:0] out_t;

  // one-result credit between input and output
  typedef enum logic {
    CREDIT_FREE = 1'b0,
    CREDIT_USED = 1'b1
  } credit_state_t;

  // output holder occupancy
  typedef enum logic {
    HOLD_EMPTY = 1'b0,
    HOLD_FULL  = 1'b1
  } hold_state_t;

endpackage

`default_nettype wire

//--- rtl/cic_sample_gate.sv
// --------------------------------------------------------------------------
// cic sample gate
// accepts input samples, sign-extends them to the accumulator width,
// counts decimation groups and holds the one-result credit
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_sample_gate
  import cic_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  sample_t                    in_data,
  input  logic [`CIC_RATE_WIDTH-1:0] decim_rate,
  input  logic                       result_taken,
  output logic                       samp_valid,
  output acc_t                       samp_data,
  output logic                       samp_last
);

  logic [`CIC_RATE_WIDTH-1:0] rate_clamped;
  logic [`CIC_RATE_WIDTH-1:0] rate_q;
  logic [`CIC_RATE_WIDTH-1:0] grp_count;
  logic                       started;
  credit_state_t              credit;
  logic                       closing;
  logic                       accept;
  sample_t                    data_q;
  logic                       valid_q;
  logic                       last_q;

  // requests below the minimum ratio are raised to it
  assign rate_clamped = (decim_rate < `CIC_RATE_WIDTH'(`CIC_MIN_RATE)) ?
                        `CIC_RATE_WIDTH'(`CIC_MIN_RATE) : decim_rate;

  // counter sits on the last sample of the group
  assign closing = (grp_count == rate_q - 1'b1);

  // only the closing sample waits for the credit
  assign in_ready = !(closing && (credit == CREDIT_USED));
  assign accept   = in_valid && in_ready;

  // --------------------------------------------------------------------------
  // group counter and ratio latch
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      grp_count <= '0;
      rate_q    <= `CIC_RATE_WIDTH'(`CIC_MIN_RATE);
      started   <= 1'b0;
    end else begin
      if (accept) begin
        started <= 1'b1;
        if (closing) begin
          grp_count <= '0;
        end else begin
          grp_count <= grp_count + 1'b1;
        end
      end
      // ratio follows the port until the first sample, then only at group close
      if (!started || (accept && closing)) begin
        rate_q <= rate_clamped;
      end
    end
  end

  // credit taken by the closing sample, returned by the output transfer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      credit <= CREDIT_FREE;
    end else if (accept && closing) begin
      credit <= CREDIT_USED;
    end else if (result_taken) begin
      credit <= CREDIT_FREE;
    end
  end

  // --------------------------------------------------------------------------
  // input register, then sign extension into the sample stage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q    <= 1'b0;
      last_q     <= 1'b0;
      samp_valid <= 1'b0;
      samp_last  <= 1'b0;
    end else begin
      valid_q    <= accept;
      last_q     <= accept && closing;
      samp_valid <= valid_q;
      samp_last  <= last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q <= in_data;
    end
    if (valid_q) begin
      samp_data <= {{(`CIC_ACC_WIDTH-`CIC_IN_WIDTH){data_q[`CIC_IN_WIDTH-1]}}, data_q};
    end
  end

endmodule

`default_nettype wire

//--- rtl/cic_integrator_chain.sv
// --------------------------------------------------------------------------
// cic integrator chain
// cascade of wrap-around integrators, stepped once per input sample
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_integrator_chain
  import cic_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic samp_valid,
  input  acc_t samp_data,
  input  logic samp_last,
  output logic int_valid,
  output acc_t int_data,
  output logic int_last
);

  acc_t acc      [`CIC_STAGES];
  acc_t stage_in [`CIC_STAGES];

  assign stage_in[0] = samp_data;

  // each stage adds the registered value of the one before it
  for (genvar s = 0; s < `CIC_STAGES; s++) begin : g_stage
    if (s > 0) begin : g_link
      assign stage_in[s] = acc[s-1];
    end

    // sum wraps at the accumulator width
    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        acc[s] <= '0;
      end else if (samp_valid) begin
        acc[s] <= acc[s] + stage_in[s];
      end
    end
  end

  // flags ride alongside the last stage
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      int_valid <= 1'b0;
      int_last  <= 1'b0;
    end else begin
      int_valid <= samp_valid;
      int_last  <= samp_valid && samp_last;
    end
  end

  assign int_data = acc[`CIC_STAGES-1];

endmodule

`default_nettype wire

//--- rtl/cic_comb_chain.sv
// --------------------------------------------------------------------------
// cic comb chain
// cascaded differences against the previous group close, one result
// registered per group
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_comb_chain
  import cic_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic int_valid,
  input  acc_t int_data,
  input  logic int_last,
  output logic comb_valid,
  output acc_t comb_data
);

  acc_t dly      [`CIC_STAGES];
  acc_t stage_in [`CIC_STAGES];
  acc_t diff     [`CIC_STAGES];
  logic close_grp;

  assign close_grp = int_valid && int_last;

  // differences chained combinationally
  always_comb begin
    stage_in[0] = int_data;
    diff[0]     = int_data - dly[0];
    for (int s = 1; s < `CIC_STAGES; s++) begin
      stage_in[s] = diff[s-1];
      diff[s]     = diff[s-1] - dly[s];
    end
  end

  // --------------------------------------------------------------------------
  // delay registers, updated only when a group closes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int s = 0; s < `CIC_STAGES; s++) begin
        dly[s] <= '0;
      end
    end else if (close_grp) begin
      for (int s = 0; s < `CIC_STAGES; s++) begin
        dly[s] <= stage_in[s];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      comb_valid <= 1'b0;
    end else begin
      comb_valid <= close_grp;
    end
  end

  // final difference
  always_ff @(posedge clk) begin
    if (close_grp) begin
      comb_data <= diff[`CIC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

//--- rtl/cic_output_stage.sv
// --------------------------------------------------------------------------
// cic output stage
// arithmetic right shift, half-up rounding and saturation to the output
// width, with a one-entry holder on the valid/ready output
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_output_stage
  import cic_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        comb_valid,
  input  acc_t                        comb_data,
  input  logic [`CIC_SHIFT_WIDTH-1:0] out_shift,
  input  logic                        out_ready,
  output logic                        out_valid,
  output out_t                        out_data,
  output logic                        result_taken
);

  localparam out_t OUT_MAX = {1'b0, {(`CIC_OUT_WIDTH-1){1'b1}}};
  localparam out_t OUT_MIN = {1'b1, {(`CIC_OUT_WIDTH-1){1'b0}}};

  logic [`CIC_ACC_WIDTH:0] data_ext;
  logic                    round_bit;
  acc_t                    shifted;
  acc_t                    rounded;
  logic                    fits;
  out_t                    sat_value;
  hold_state_t             hold_state;

  // --------------------------------------------------------------------------
  // scaling
  // --------------------------------------------------------------------------

  // a zero appended below bit 0 gives the bit under the cut, zero for no shift
  assign data_ext  = {comb_data, 1'b0};
  assign round_bit = data_ext[out_shift];
  assign shifted   = comb_data >>> out_shift;

  // no overflow since a nonzero round bit means some bit was shifted out
  assign rounded = shifted + acc_t'(round_bit);

  // in range when every bit above the output msb copies the sign
  assign fits = (rounded[`CIC_ACC_WIDTH-1:`CIC_OUT_WIDTH-1] ==
                 {(`CIC_ACC_WIDTH-`CIC_OUT_WIDTH+1){rounded[`CIC_ACC_WIDTH-1]}});

  always_comb begin
    if (fits) begin
      sat_value = rounded[`CIC_OUT_WIDTH-1:0];
    end else if (rounded[`CIC_ACC_WIDTH-1]) begin
      sat_value = OUT_MIN;
    end else begin
      sat_value = OUT_MAX;
    end
  end

  // --------------------------------------------------------------------------
  // output holder
  // --------------------------------------------------------------------------

  // the credit upstream keeps a new result from landing on a full holder
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hold_state <= HOLD_EMPTY;
    end else if (comb_valid) begin
      hold_state <= HOLD_FULL;
    end else if (out_valid && out_ready) begin
      hold_state <= HOLD_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (comb_valid) begin
      out_data <= sat_value;
    end
  end

  assign out_valid    = (hold_state == HOLD_FULL);

  // returns the credit to the sample gate
  assign result_taken = out_valid && out_ready;

endmodule

`default_nettype wire

//--- rtl/cic_decimator_top.sv
// --------------------------------------------------------------------------
// cic decimator top
// third-order cic decimation filter, sample gate through integrators and
// combs to the scaled, saturated output
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module cic_decimator_top
  import cic_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  sample_t                     in_data,
  input  logic [`CIC_RATE_WIDTH-1:0]  decim_rate,
  input  logic [`CIC_SHIFT_WIDTH-1:0] out_shift,
  output logic                        out_valid,
  input  logic                        out_ready,
  output out_t                        out_data
);

  // sample gate to integrators
  logic samp_valid;
  acc_t samp_data;
  logic samp_last;

  // integrators to combs
  logic int_valid;
  acc_t int_data;
  logic int_last;

  // combs to output stage
  logic comb_valid;
  acc_t comb_data;

  // credit return
  logic result_taken;

  cic_sample_gate u_sample_gate (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .decim_rate   (decim_rate),
    .result_taken (result_taken),
    .samp_valid   (samp_valid),
    .samp_data    (samp_data),
    .samp_last    (samp_last)
  );

  cic_integrator_chain u_integrator_chain (
    .clk        (clk),
    .reset      (reset),
    .samp_valid (samp_valid),
    .samp_data  (samp_data),
    .samp_last  (samp_last),
    .int_valid  (int_valid),
    .int_data   (int_data),
    .int_last   (int_last)
  );

  cic_comb_chain u_comb_chain (
    .clk        (clk),
    .reset      (reset),
    .int_valid  (int_valid),
    .int_data   (int_data),
    .int_last   (int_last),
    .comb_valid (comb_valid),
    .comb_data  (comb_data)
  );

  cic_output_stage u_output_stage (
    .clk          (clk),
    .reset        (reset),
    .comb_valid   (comb_valid),
    .comb_data    (comb_data),
    .out_shift    (out_shift),
    .out_ready    (out_ready),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .result_taken (result_taken)
  );

endmodule

`default_nettype wire

//--- testbench/tb_cic_decimator.sv
// --------------------------------------------------------------------------
// cic decimator testbench
// directed tests against a bit-exact model of the third-order cic filter,
// with an output monitor, a watchdog and a closing summary
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "cic_cfg.svh"

module tb_cic_decimator
  import cic_pkg::*;
();

  localparam int CLK_PERIOD    = 10;
  localparam int TOTAL_SAMPLES = 24 + 96 + 40 + 512 + 46;
  localparam int WATCHDOG_NS   = (TOTAL_SAMPLES * 8 + 1000) * CLK_PERIOD;

  logic                        clk;
  logic                        reset;
  logic                        in_valid;
  logic                        in_ready;
  sample_t                     in_data;
  logic [`CIC_RATE_WIDTH-1:0]  decim_rate;
  logic [`CIC_SHIFT_WIDTH-1:0] out_shift;
  logic                        out_valid;
  logic                        out_ready;
  out_t                        out_data;

  // reference model state
  acc_t  m_int [`CIC_STAGES];
  acc_t  m_dly [`CIC_STAGES];
  int    m_count;
  int    m_rate;
  bit    m_started;
  out_t  exp_q[$];
  time   close_t_q[$];

  string test_name;
  int    err_count;
  int    err_start;
  int    check_count;
  int    n_received;
  bit    lat_check;
  bit    stall_seen;
  bit    sending_done;
  out_t  last_out;
  out_t  mon_exp;
  time   mon_close;
  int    mon_lat;

  cic_decimator_top UUT (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .decim_rate (decim_rate),
    .out_shift  (out_shift),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR test=%s: %s", test_name, msg);
  endtask

  task automatic report_mismatch(input string what, input longint expected,
                                 input longint actual);
    err_count++;
    $display("MISMATCH test=%s %s expected=%0d actual=%0d", test_name, what, expected, actual);
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic int clamp_rate(input logic [`CIC_RATE_WIDTH-1:0] r);
    int rv;
    rv = int'(r);
    if (rv < `CIC_MIN_RATE) begin
      return `CIC_MIN_RATE;
    end
    return rv;
  endfunction

  // floor((v + half lsb) / 2^sh) clamped to the signed 32-bit range
  function automatic out_t scale_result(input acc_t v, input int sh);
    logic signed [127:0] wide;
    logic signed [127:0] half;
    wide = 128'(v);
    half = (sh > 0) ? (128'sd1 <<< (sh - 1)) : 128'sd0;
    wide = (wide + half) >>> sh;
    if (wide > 128'sd2147483647) begin
      return 32'sh7fffffff;
    end
    if (wide < -128'sd2147483648) begin
      return 32'sh80000000;
    end
    return out_t'(wide);
  endfunction

  function automatic bit closing_next();
    return m_count == (m_started ? m_rate : clamp_rate(decim_rate)) - 1;
  endfunction

  function automatic void model_accept(input sample_t x);
    acc_t nxt [`CIC_STAGES];
    acc_t c;
    acc_t prev;
    if (!m_started) begin
      m_rate    = clamp_rate(decim_rate);
      m_started = 1'b1;
    end
    // every stage adds the old value of the one before it
    nxt[0] = m_int[0] + acc_t'(x);
    for (int s = 1; s < `CIC_STAGES; s++) begin
      nxt[s] = m_int[s] + m_int[s-1];
    end
    m_int = nxt;
    m_count++;
    if (m_count == m_rate) begin
      c = m_int[`CIC_STAGES-1];
      for (int s = 0; s < `CIC_STAGES; s++) begin
        prev     = m_dly[s];
        m_dly[s] = c;
        c        = c - prev;
      end
      exp_q.push_back(scale_result(c, int'(out_shift)));
      close_t_q.push_back($time);
      m_count = 0;
      // new ratio applies from the next group on
      m_rate  = clamp_rate(decim_rate);
    end
  endfunction

  // --------------------------------------------------------------------------
  // stimulus helpers
  // --------------------------------------------------------------------------
  task automatic apply_reset(input int rate, input int shift);
    reset      <= 1'b1;
    in_valid   <= 1'b0;
    out_ready  <= 1'b1;
    decim_rate <= `CIC_RATE_WIDTH'(rate);
    out_shift  <= `CIC_SHIFT_WIDTH'(shift);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    exp_q.delete();
    close_t_q.delete();
    for (int s = 0; s < `CIC_STAGES; s++) begin
      m_int[s] = '0;
      m_dly[s] = '0;
    end
    m_count    = 0;
    m_rate     = `CIC_MIN_RATE;
    m_started  = 1'b0;
    lat_check  = 1'b0;
    stall_seen = 1'b0;
    n_received = 0;
    @(posedge clk);
  endtask

  // holds the sample until accepted and samples ready at the falling edge
  task automatic send_sample(input sample_t x);
    bit taken;
    taken = 1'b0;
    in_valid <= 1'b1;
    in_data  <= x;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      if (!in_ready) begin
        stall_seen = 1'b1;
        if (!closing_next()) begin
          report_error("in_ready low on a sample that does not close a group");
        end
      end
      @(posedge clk);
    end
    model_accept(x);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 400) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d expected results never arrived", exp_q.size()));
    end
    repeat (2) @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = err_count;
  endtask

  task automatic end_test();
    $display("test %-14s %s (%0d errors)", test_name,
             (err_count == err_start) ? "ok" : "FAILED", err_count - err_start);
  endtask

  // --------------------------------------------------------------------------
  // output monitor, one comparison per transfer
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (!reset && out_valid && out_ready) begin
      check_count++;
      n_received++;
      last_out = out_data;
      if (exp_q.size() == 0) begin
        report_error("output transfer with no result expected");
      end else begin
        mon_exp   = exp_q.pop_front();
        mon_close = close_t_q.pop_front();
        mon_lat   = int'(($time - mon_close) / CLK_PERIOD);
        if (out_data !== mon_exp) begin
          report_mismatch("out_data", mon_exp, out_data);
        end
        if (lat_check && mon_lat != 4) begin
          report_mismatch("latency", 4, mon_lat);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_reset_state();
    begin_test("reset_state");
    apply_reset(4, 0);
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      report_mismatch("out_valid", 0, out_valid);
    end
    if (in_ready !== 1'b1) begin
      report_mismatch("in_ready", 1, in_ready);
    end
    end_test();
  endtask

  task automatic test_dc_input();
    begin_test("dc_input");
    apply_reset(4, 0);
    repeat (24) send_sample(16'sd1000);
    in_valid <= 1'b0;
    wait_drain();
    // gain of R^3 once the combs have settled
    if (last_out !== 32'sd64000) begin
      report_mismatch("settled out_data", 64000, last_out);
    end
    if (n_received != 6) begin
      report_mismatch("result count", 6, n_received);
    end
    end_test();
  endtask

  task automatic test_random();
    begin_test("random_r8");
    apply_reset(8, 5);
    lat_check = 1'b1;
    repeat (96) send_sample(sample_t'($urandom));
    in_valid <= 1'b0;
    wait_drain();
    lat_check = 1'b0;
    if (n_received != 12) begin
      report_mismatch("result count", 12, n_received);
    end
    end_test();
  endtask

  task automatic test_backpressure();
    begin_test("backpressure");
    apply_reset(4, 0);
    out_ready    <= 1'b0;
    sending_done = 1'b0;
    fork
      begin
        repeat (40) send_sample(sample_t'($urandom));
        in_valid <= 1'b0;
        sending_done = 1'b1;
      end
      begin
        // a long hold first and then a random drain pattern
        repeat (40) @(posedge clk);
        while (!sending_done) begin
          out_ready <= 1'($urandom % 2);
          @(posedge clk);
        end
        out_ready <= 1'b1;
      end
    join
    wait_drain();
    if (!stall_seen) begin
      report_error("input never stalled while the output was blocked");
    end
    if (n_received != 10) begin
      report_mismatch("result count", 10, n_received);
    end
    end_test();
  endtask

  task automatic test_saturation();
    begin_test("saturation");
    apply_reset(64, 0);
    repeat (256) send_sample(16'sh7fff);
    in_valid <= 1'b0;
    wait_drain();
    if (last_out !== 32'sh7fffffff) begin
      report_mismatch("positive clamp", 32'sh7fffffff, last_out);
    end
    repeat (256) send_sample(16'sh8000);
    in_valid <= 1'b0;
    wait_drain();
    if (last_out !== 32'sh80000000) begin
      report_mismatch("negative clamp", 32'sh80000000, last_out);
    end
    end_test();
  endtask

  task automatic test_rate_change();
    begin_test("rate_change");
    apply_reset(4, 0);
    repeat (14) send_sample(sample_t'($urandom));
    // the current group still closes at 4 after this mid-group switch
    decim_rate <= `CIC_RATE_WIDTH'(10);
    repeat (32) send_sample(sample_t'($urandom));
    in_valid <= 1'b0;
    wait_drain();
    if (n_received != 7) begin
      report_mismatch("result count", 7, n_received);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(50));
    clk         = 1'b0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_data     = '0;
    decim_rate  = `CIC_RATE_WIDTH'(4);
    out_shift   = '0;
    out_ready   = 1'b1;
    err_count   = 0;
    check_count = 0;
    last_out    = '0;
    test_name   = "startup";
    test_reset_state();
    test_dc_input();
    test_random();
    test_backpressure();
    test_saturation();
    test_rate_change();
    $display("summary: 6 tests, %0d output checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog sized from the total sample count
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired at %0t during test %s", $time, test_name);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/cic_pkg.sv
rtl/cic_sample_gate.sv
rtl/cic_integrator_chain.sv
rtl/cic_comb_chain.sv
rtl/cic_output_stage.sv
rtl/cic_decimator_top.sv
testbench/tb_cic_decimator.sv

//--- Makefile
# Verilator build and run for the CIC decimator testbench

TOP     = tb_cic_decimator
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	@if grep -q ">>> FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) sim.log
